// File: list.f
+incdir+hdl
hdl/icache_geom_pkg.sv
hdl/fetch_bus_pkg.sv
hdl/store_if.sv
hdl/tag_array.sv
hdl/data_array.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
verification/tb_stim.sv
verification/tb_top.sv

// File: verification/tb_top.sv
/* Testbench top for the instruction cache with clock, reset, refill memory model,
   reference tracker, assertions and watchdog. Fetch stimulus comes from tb_stim. */

`timescale 1ns/1ns
`include "icache_params.svh"

module tb_top;
  import fetch_bus_pkg::*;
  import icache_geom_pkg::*;

  // Tracker view of the request in flight
  typedef enum {PH_IDLE, PH_COMPARE, PH_ACK, PH_DATA, PH_KILLED, PH_REFILLED} phase_e;

  logic   clk, rst_n, en, fetch_req, kill_s1, kill_s2, stim_done;
  addr_t  fetch_addr, fetch_addr_out, mem_addr;
  logic   fetch_ready, fetch_valid, miss, mem_req, mem_ack, mem_rtrn_vld;
  word_t  fetch_data;
  line_t  mem_rtrn_line;

  phase_e phase = PH_IDLE;
  addr_t  cur_addr, cur_maddr;           // Request under service and its refill address
  logic   cur_cache;
  addr_t  exp_q[$];                      // Accepted and not killed in arrival order
  logic [`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W] line_tab [`ICACHE_LINES];
  bit     line_ok [`ICACHE_LINES];       // Cold after reset
  int     accepted = 0;

  icache_top u_icache_top (
    .clk_i (clk), .rst_ni (rst_n), .en_i (en),
    .fetch_req_i (fetch_req), .fetch_addr_i (fetch_addr),
    .kill_s1_i (kill_s1), .kill_s2_i (kill_s2),
    .fetch_ready_o (fetch_ready), .fetch_valid_o (fetch_valid),
    .fetch_data_o (fetch_data), .fetch_addr_o (fetch_addr_out),
    .miss_o (miss), .mem_req_o (mem_req), .mem_addr_o (mem_addr),
    .mem_ack_i (mem_ack), .mem_rtrn_vld_i (mem_rtrn_vld), .mem_rtrn_line_i (mem_rtrn_line)
  );

  tb_stim u_tb_stim (
    .clk_i (clk), .rst_ni (rst_n), .fetch_ready_i (fetch_ready), .mem_ack_i (mem_ack),
    .en_o (en), .fetch_req_o (fetch_req), .fetch_addr_o (fetch_addr),
    .kill_s1_o (kill_s1), .kill_s2_o (kill_s2), .done_o (stim_done)
  );

  // Word k of the line at address a
  function automatic word_t mem_word(addr_t a, logic [1:0] k);
    return {a[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], k, 2'b00} ^ 32'h5A5A_0000;
  endfunction

  function automatic line_t build_line(addr_t a);
    line_t l;
    for (int k = 0; k < 4; k++) begin
      l[k*`ICACHE_WORD_W +: `ICACHE_WORD_W] = mem_word(a, 2'(k));
    end
    return l;
  endfunction

  task automatic stop_fail();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
    stop_fail();
  endtask

  task automatic run_error(input string what);
    $display("Error at %0t: %s", $time, what);
    stop_fail();
  endtask

  // **************************************************
  // Clock, reset and refill memory model
  // **************************************************
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
  end

  initial begin : mem_model
    int    seed;
    int    ack_wait;
    int    ret_wait;
    addr_t ref_addr;
    seed          = 49;
    void'($urandom(seed));
    ack_wait      = -1;
    ret_wait      = -1;
    ref_addr      = '0;
    mem_ack       = 1'b0;
    mem_rtrn_vld  = 1'b0;
    mem_rtrn_line = '0;
    forever begin
      @(posedge clk);
      #2;                                    // After stim and DUT settle
      mem_ack      = 1'b0;
      mem_rtrn_vld = 1'b0;
      if (ret_wait == 0) begin
        mem_rtrn_vld  = 1'b1;
        mem_rtrn_line = build_line(ref_addr);
        ret_wait      = -1;
      end else if (ret_wait > 0) begin
        ret_wait--;
      end else if (mem_req) begin
        if (ack_wait < 0) begin
          ack_wait = $urandom_range(0, 3);   // Ack 0 to 3 cycles late
        end
        if (ack_wait == 0) begin
          mem_ack  = 1'b1;
          ref_addr = mem_addr;
          ret_wait = $urandom_range(0, 3);   // Return 1 to 4 cycles after ack
        end
        ack_wait--;
      end
    end
  end

  // **************************************************
  // Reference tracker and checks
  // **************************************************
  always @(posedge clk) begin : tracker
    phase_e ph_n;
    logic   exp_valid, exp_miss, exp_req, drop, hit;
    int     idx;
    if (rst_n) begin
      ph_n      = phase;
      exp_valid = 1'b0;
      exp_miss  = 1'b0;
      exp_req   = 1'b0;
      drop      = 1'b0;
      idx       = cur_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
      case (phase)
        PH_COMPARE: begin
          hit = line_ok[idx] && line_tab[idx] == cur_addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W];
          if (kill_s2) begin
            drop = 1'b1;
            ph_n = PH_IDLE;
          end else if (hit) begin
            exp_valid = 1'b1;
            ph_n      = PH_IDLE;
          end else begin
            exp_miss = 1'b1;
            exp_req  = 1'b1;
            ph_n     = mem_ack ? PH_DATA : PH_ACK;
          end
        end
        PH_ACK: begin
          exp_req = 1'b1;                    // Kill ignored here
          if (mem_ack) ph_n = PH_DATA;
        end
        PH_DATA: begin
          if (mem_rtrn_vld && kill_s2) begin
            drop = 1'b1;
            ph_n = PH_IDLE;
          end else if (mem_rtrn_vld) begin
            exp_valid = 1'b1;
            ph_n      = cur_cache ? PH_REFILLED : PH_IDLE;
            if (cur_cache) begin
              line_ok[idx]  = 1'b1;
              line_tab[idx] = cur_addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W];
            end
          end else if (kill_s2) begin
            drop = 1'b1;
            ph_n = PH_KILLED;
          end
        end
        PH_KILLED: if (mem_rtrn_vld) ph_n = PH_IDLE;
        default: ph_n = PH_IDLE;
      endcase

      // New fetch accepted when the tracker is idle
      if (ph_n == PH_IDLE && fetch_req && !kill_s1) begin
        accepted++;
        cur_addr  = fetch_addr;
        cur_cache = en && !fetch_addr[`ICACHE_NC_BIT];
        if (cur_cache) begin
          cur_maddr = {fetch_addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], 4'h0};
        end else begin
          cur_maddr = {fetch_addr[`ICACHE_ADDR_W-1:2], 2'b00};
          exp_req   = 1'b1;
        end
      end

      assert (fetch_ready === (ph_n == PH_IDLE))
        else value_error("fetch_ready_o", ph_n == PH_IDLE, fetch_ready);
      assert (fetch_valid === exp_valid) else value_error("fetch_valid_o", exp_valid, fetch_valid);
      assert (miss === exp_miss) else value_error("miss_o", exp_miss, miss);
      assert (mem_req === exp_req) else value_error("mem_req_o", exp_req, mem_req);
      if (exp_req) begin
        assert (mem_addr === cur_maddr) else value_error("mem_addr_o", cur_maddr, mem_addr);
      end
      if (exp_valid) begin
        assert (fetch_addr_out === exp_q[0])
          else value_error("fetch_addr_o", exp_q[0], fetch_addr_out);
        assert (fetch_data === mem_word(exp_q[0], exp_q[0][3:2]))
          else value_error("fetch_data_o", mem_word(exp_q[0], exp_q[0][3:2]), fetch_data);
        void'(exp_q.pop_front());
      end
      if (drop) void'(exp_q.pop_front());

      // Push after the pop since a hit overlaps the next acceptance
      if (ph_n == PH_IDLE && fetch_req && !kill_s1) begin
        exp_q.push_back(fetch_addr);
        ph_n = cur_cache ? PH_COMPARE : (mem_ack ? PH_DATA : PH_ACK);
      end
      phase <= ph_n;
    end
  end

  // **************************************************
  // Watchdog and end of run
  // **************************************************
  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > 200 * (accepted + 1)) run_error("timeout, the cache stopped making progress");
    end
  end

  initial begin
    wait (stim_done);
    if (exp_q.size() != 0) begin
      run_error("accepted fetches never returned a word");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// File: verification/tb_stim.sv
/* Fetch stimulus for the cache testbench, driven 1 ns after each rising edge.
   Covers hit streams, conflicts, bypass fetches, kills and a random mix. */

`timescale 1ns/1ns

module tb_stim (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 fetch_ready_i,
  input  logic                 mem_ack_i,
  output logic                 en_o,
  output logic                 fetch_req_o,
  output fetch_bus_pkg::addr_t fetch_addr_o,
  output logic                 kill_s1_o,
  output logic                 kill_s2_o,
  output logic                 done_o
);
  import fetch_bus_pkg::*;

  // Hold a request until ready, optional kill in the following cycle
  task automatic fetch(input addr_t a, input logic en, input logic k1, input logic k2);
    en_o         = en;
    fetch_req_o  = 1'b1;
    fetch_addr_o = a;
    kill_s1_o    = k1;
    do @(posedge clk_i); while (!fetch_ready_i);
    #1;
    fetch_req_o = 1'b0;
    kill_s1_o   = 1'b0;
    en_o        = 1'b1;
    if (k2) begin
      kill_s2_o = 1'b1;                      // Compare cycle, or refill for bypass
      @(posedge clk_i);
      #1;
      kill_s2_o = 1'b0;
    end
  endtask

  // Cacheable miss killed right after the bus acknowledge
  task automatic kill_refill(input addr_t a);
    fetch(a, 1'b1, 1'b0, 1'b0);
    do @(posedge clk_i); while (!mem_ack_i);
    #1;
    kill_s2_o = 1'b1;
    @(posedge clk_i);
    #1;
    kill_s2_o = 1'b0;
  endtask

  initial begin
    addr_t a;
    en_o         = 1'b1;
    fetch_req_o  = 1'b0;
    fetch_addr_o = '0;
    kill_s1_o    = 1'b0;
    kill_s2_o    = 1'b0;
    done_o       = 1'b0;
    wait (rst_ni);
    @(posedge clk_i);
    #1;
    // Cold miss then hits on the same line, then a hit stream
    for (int i = 0; i < 12; i++) fetch(32'h0000_1000 + (i % 4) * 4, 1'b1, 1'b0, 1'b0);
    fetch(32'h0000_2004, 1'b1, 1'b0, 1'b0);  // Same index, evicts
    fetch(32'h0000_1008, 1'b1, 1'b0, 1'b0);
    // High addresses and en low never allocate
    fetch(32'h8000_1004, 1'b1, 1'b0, 1'b0);
    fetch(32'h8000_1004, 1'b1, 1'b0, 1'b0);
    fetch(32'h0000_100C, 1'b0, 1'b0, 1'b0);
    fetch(32'h0000_3000, 1'b0, 1'b0, 1'b0);
    fetch(32'h0000_1000, 1'b1, 1'b0, 1'b0);  // Still a hit
    // Kills at each point
    fetch(32'h0000_1004, 1'b1, 1'b1, 1'b0);
    fetch(32'h0000_1004, 1'b1, 1'b0, 1'b1);
    fetch(32'h0000_6010, 1'b1, 1'b0, 1'b1);
    kill_refill(32'h0000_5020);
    fetch(32'h0000_5024, 1'b1, 1'b0, 1'b0);
    // Random mix over a few tags and indexes
    for (int i = 0; i < 48; i++) begin
      a = $urandom & 32'h8000_30FC;
      if (i % 12 == 11) begin
        kill_refill(32'h0000_4000 + i * 16);
        fetch(32'h0000_4004 + i * 16, 1'b1, 1'b0, 1'b0);
      end else begin
        fetch(a, $urandom_range(0, 7) != 0, $urandom_range(0, 9) == 0,
              $urandom_range(0, 7) == 0);
      end
    end
    // Drain the last request
    repeat (2) @(posedge clk_i);
    while (!fetch_ready_i) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    #1;
    done_o = 1'b1;
  end

endmodule

// File: hdl/icache_top.sv
/* Direct-mapped instruction cache between a fetch unit and a line refill bus.
   Connects the controller to the tag and data stores through one storage port. */

`timescale 1ns/1ns

module icache_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   en_i,             // Cache enable, low bypasses all
  // Fetch port
  input  logic                   fetch_req_i,
  input  fetch_bus_pkg::addr_t   fetch_addr_i,
  input  logic                   kill_s1_i,        // Kill at acceptance
  input  logic                   kill_s2_i,        // Kill at compare or refill
  output logic                   fetch_ready_o,
  output logic                   fetch_valid_o,    // One-cycle pulse
  output fetch_bus_pkg::word_t   fetch_data_o,
  output fetch_bus_pkg::addr_t   fetch_addr_o,
  // Performance counter
  output logic                   miss_o,
  // Refill bus
  output logic                   mem_req_o,
  output fetch_bus_pkg::addr_t   mem_addr_o,
  input  logic                   mem_ack_i,
  input  logic                   mem_rtrn_vld_i,
  input  icache_geom_pkg::line_t mem_rtrn_line_i
);

  // **************************************************
  // Storage port shared by controller and arrays
  // **************************************************
  store_if st_bus ();

  // **************************************************
  // Controller
  // **************************************************
  icache_ctrl u_icache_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .en_i            (en_i),
    .fetch_req_i     (fetch_req_i),
    .fetch_addr_i    (fetch_addr_i),
    .kill_s1_i       (kill_s1_i),
    .kill_s2_i       (kill_s2_i),
    .fetch_ready_o   (fetch_ready_o),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_data_o    (fetch_data_o),
    .fetch_addr_o    (fetch_addr_o),
    .miss_o          (miss_o),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_ack_i       (mem_ack_i),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_line_i (mem_rtrn_line_i),
    .st              (st_bus.ctrl)
  );

  // **************************************************
  // Storage arrays
  // **************************************************

  // Tags, valid bits and the hit compare
  tag_array u_tag_array (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .st     (st_bus.tag)
  );

  // Line data, read alongside the tags
  data_array u_data_array (
    .clk_i (clk_i),
    .st    (st_bus.data)
  );

endmodule

// File: hdl/icache_ctrl.sv
/* Cache controller with request register, bypass decode, FSM and word select.
   Drives the storage port and the refill bus, returns words to the fetch unit. */

`timescale 1ns/1ns
`include "icache_params.svh"

module icache_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   en_i,             // Low forces bypass
  // Fetch port
  input  logic                   fetch_req_i,
  input  fetch_bus_pkg::addr_t   fetch_addr_i,
  input  logic                   kill_s1_i,
  input  logic                   kill_s2_i,
  output logic                   fetch_ready_o,
  output logic                   fetch_valid_o,
  output fetch_bus_pkg::word_t   fetch_data_o,
  output fetch_bus_pkg::addr_t   fetch_addr_o,
  output logic                   miss_o,           // Cacheable miss pulse
  // Refill bus
  output logic                   mem_req_o,
  output fetch_bus_pkg::addr_t   mem_addr_o,
  input  logic                   mem_ack_i,
  input  logic                   mem_rtrn_vld_i,
  input  icache_geom_pkg::line_t mem_rtrn_line_i,
  // Tag and data stores
  store_if.ctrl                  st
);
  import icache_geom_pkg::*;
  import fetch_bus_pkg::*;

  // **************************************************
  // Internal signals
  // **************************************************
  ctrl_state_e state_q, state_d;
  addr_t       req_addr_d, req_addr_q;   // Request under service
  logic        bypass_in;                // Incoming fetch skips the cache
  logic        bypass_d, bypass_q;
  logic        accept;                   // Fetch taken this cycle
  logic        take_new;                 // State may open ready
  offset_t     req_off;

  // Word at the byte offset of a line
  function automatic word_t pick_word(line_t line, offset_t off);
    return line[off[`ICACHE_OFFSET_W-1:2] * `ICACHE_WORD_W +: `ICACHE_WORD_W];
  endfunction

  // **************************************************
  // Request capture and bypass decode
  // **************************************************
  assign accept     = fetch_ready_o & fetch_req_i;
  assign bypass_in  = ~en_i | fetch_addr_i[`ICACHE_NC_BIT];  // Upper half is I/O
  assign req_addr_d = accept ? fetch_addr_i : req_addr_q;
  assign bypass_d   = accept ? bypass_in : bypass_q;
  assign req_off    = req_addr_q[`ICACHE_OFFSET_W-1:0];

  assign fetch_addr_o = req_addr_q;   // Travels with the valid pulse

  // Index from the incoming address, read lands in compare cycle
  assign st.index = req_addr_d[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
  assign st.wtag  = req_addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];  // Compare and fill tag
  assign st.wline = mem_rtrn_line_i;

  // Refill address, word aligned for bypass and line aligned otherwise
  assign mem_addr_o = bypass_d ?
                      {req_addr_d[`ICACHE_ADDR_W-1:2], 2'b00} :
                      {req_addr_d[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                       {`ICACHE_OFFSET_W{1'b0}}};

  // **************************************************
  // Controller FSM
  // **************************************************
  always_comb begin
    state_d       = state_q;
    take_new      = 1'b0;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    fetch_data_o  = '0;
    miss_o        = 1'b0;
    mem_req_o     = 1'b0;
    st.en         = 1'b0;
    st.we         = 1'b0;

    case (state_q)
      IDLE: begin
        take_new = 1'b1;
      end

      TAG_COMPARE: begin
        if (kill_s2_i) begin
          take_new = 1'b1;                       // Drop it, reopen at once
        end else if (st.hit) begin
          fetch_valid_o = 1'b1;
          fetch_data_o  = pick_word(st.rline, req_off);
          take_new      = 1'b1;                  // Back-to-back hits
        end else begin
          miss_o    = 1'b1;
          mem_req_o = 1'b1;
          state_d   = mem_ack_i ? WAIT_MEM_DONE : WAIT_MEM_ACK;
        end
      end

      WAIT_MEM_ACK: begin
        // Kill has no effect until the request is acknowledged
        mem_req_o = 1'b1;
        if (mem_ack_i) begin
          state_d = WAIT_MEM_DONE;
        end
      end

      WAIT_MEM_DONE: begin
        if (mem_rtrn_vld_i) begin
          if (kill_s2_i) begin
            take_new = 1'b1;                     // Data dropped, nothing filled
          end else begin
            fetch_valid_o = 1'b1;
            fetch_data_o  = pick_word(mem_rtrn_line_i, req_off);
            if (!bypass_q) begin
              st.en   = 1'b1;                    // Allocate the line
              st.we   = 1'b1;
              state_d = IDLE;                    // Ready back next cycle
            end else begin
              take_new = 1'b1;
            end
          end
        end else if (kill_s2_i) begin
          state_d = WAIT_KILL;
        end
      end

      WAIT_KILL: begin
        if (mem_rtrn_vld_i) begin
          take_new = 1'b1;                       // Swallow the late line
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // **************************************************
    // New request, shared by every state that opens ready
    // **************************************************
    if (take_new) begin
      fetch_ready_o = 1'b1;
      state_d       = IDLE;
      if (fetch_req_i && !kill_s1_i) begin
        if (bypass_in) begin
          mem_req_o = 1'b1;                      // Straight to the bus
          state_d   = mem_ack_i ? WAIT_MEM_DONE : WAIT_MEM_ACK;
        end else begin
          st.en   = 1'b1;                        // Read tag and line
          state_d = TAG_COMPARE;
        end
      end
    end
  end

  // **************************************************
  // Registers
  // **************************************************
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    req_addr_q <= req_addr_d;
    bypass_q   <= bypass_d;
  end

endmodule

// File: hdl/data_array.sv
/* Line store of the cache, one full line per index.
   Read one cycle after enable, written whole when a refill allocates. */

`timescale 1ns/1ns
`include "icache_params.svh"

module data_array (
  input  logic  clk_i,
  store_if.data st
);
  import icache_geom_pkg::*;

  // **************************************************
  // Line memory
  // **************************************************
  line_t line_mem [`ICACHE_LINES];

  always_ff @(posedge clk_i) begin
    if (st.en) begin
      if (st.we) begin
        line_mem[st.index] <= st.wline;  // Whole line on allocation
      end else begin
        st.rline <= line_mem[st.index];  // Lines up with tag compare
      end
    end
  end

endmodule

// File: hdl/tag_array.sv
/* Tag store with reset valid bits and the hit compare.
   Read result is registered, hit compares it against the current write tag. */

`timescale 1ns/1ns
`include "icache_params.svh"

module tag_array (
  input  logic  clk_i,
  input  logic  rst_ni,
  store_if.tag  st
);
  import icache_geom_pkg::*;

  tag_t                     tag_mem [`ICACHE_LINES];
  logic [`ICACHE_LINES-1:0] valid_q;      // One flop per line
  tag_t                     rd_tag_q;     // Tag read last cycle
  logic                     rd_valid_q;

  // Tag memory, synchronous read
  always_ff @(posedge clk_i) begin
    if (st.en && st.we) begin
      tag_mem[st.index] <= st.wtag;
    end
    if (st.en && !st.we) begin
      rd_tag_q <= tag_mem[st.index];
    end
  end

  // Valid bits, cold after reset
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q    <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      if (st.en && st.we) begin
        valid_q[st.index] <= 1'b1;
      end
      if (st.en && !st.we) begin
        rd_valid_q <= valid_q[st.index];
      end
    end
  end

  assign st.hit = rd_valid_q && (rd_tag_q == st.wtag);

endmodule

// File: hdl/store_if.sv
/* Storage port between the cache controller and the tag and data arrays.
   Reads return one cycle after en is raised with we low. */

`timescale 1ns/1ns

interface store_if;
  import icache_geom_pkg::*;

  logic   en;     // Array access this cycle
  logic   we;     // Write the line and its tag, else read
  index_t index;  // Line select for both arrays
  tag_t   wtag;   // Write tag, also the compare tag on a read
  line_t  wline;  // Refill line to allocate
  line_t  rline;  // Read line, one cycle after the read
  logic   hit;    // Stored tag valid and equal to wtag

  // Controller side
  modport ctrl (output en, we, index, wtag, wline,
                input  rline, hit);

  // Tag store with valid bits and compare
  modport tag  (input  en, we, index, wtag,
                output hit);

  // Line store
  modport data (input  en, we, index, wline,
                output rline);

endinterface

// File: hdl/fetch_bus_pkg.sv
/* Types carried on the fetch port and the refill bus.
   Imported by the controller, named in the ports of the top level. */

`include "icache_params.svh"

package fetch_bus_pkg;

  // **************************************************
  // Bus payload types
  // **************************************************

  // Byte address of a fetch or of a refill request
  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

  // Instruction word returned to the fetch unit
  typedef logic [`ICACHE_WORD_W-1:0] word_t;

endpackage

// File: hdl/icache_geom_pkg.sv
/* Cache-side types for address fields, line storage and the controller FSM.
   Shared by the controller, the storage interface and both arrays. */

`include "icache_params.svh"

package icache_geom_pkg;

  // **************************************************
  // Address fields as seen by the cache
  // **************************************************
  typedef logic [`ICACHE_TAG_W-1:0]    tag_t;     // Upper address bits
  typedef logic [`ICACHE_INDEX_W-1:0]  index_t;   // Line select
  typedef logic [`ICACHE_OFFSET_W-1:0] offset_t;  // Byte in line

  // One full cache line, word 0 in the low bits
  typedef logic [`ICACHE_LINE_W-1:0]   line_t;

  // Controller states
  typedef enum logic [2:0] {
    IDLE,           // Ready for a new fetch
    TAG_COMPARE,    // Tag and line read back, decide hit or miss
    WAIT_MEM_ACK,   // Refill request held until acknowledged
    WAIT_MEM_DONE,  // Waiting for the line to return
    WAIT_KILL       // Killed refill still in flight, swallow its data
  } ctrl_state_e;

endpackage

// File: hdl/icache_params.svh
/* Geometry and address map constants of the instruction cache.
   Included by the packages and by every block that slices addresses. */

`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// **************************************************
// Bus widths
// **************************************************
`define ICACHE_ADDR_W    32   // Fetch and refill address
`define ICACHE_WORD_W    32   // One instruction word
`define ICACHE_LINE_W    128  // Four words per line

// **************************************************
// Cache geometry
// **************************************************
`define ICACHE_LINES     64
`define ICACHE_OFFSET_W  4    // Byte offset inside a line
`define ICACHE_INDEX_W   6    // log2 of line count
`define ICACHE_TAG_W     22   // Address bits above the index
`define ICACHE_NC_BIT    31   // Set means non-cacheable, upper half of the map

`endif
